// ==== logic/bp_pkg.sv ====
`default_nettype none
//////////////////////////////
// Branch prediction package
// Shared PC width, next-PC source select
// and pattern history counter states
//////////////////////////////

package bp_pkg;

    localparam int unsigned XLEN = 32;      // PC and branch target width

    // Next-PC source for the fetch PC register
    typedef enum logic [1:0] {
        PC_SEQ         = 2'b00,             // Fetch PC plus 4
        PC_RECOVER_SEQ = 2'b01,             // Commit PC plus 4, taken prediction was wrong
        PC_BTB         = 2'b10,             // Target read from the BTB
        PC_RECOVER_TGT = 2'b11              // Commit target, not-taken prediction was wrong
    } pc_sel_e;

    // Two-bit saturating counter, upper bit is the taken prediction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,                  // Saturated not taken
        WEAK_NT   = 2'b01,                  // Reset state
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11                   // Saturated taken
    } ctr_e;

endpackage

`default_nettype wire

// ==== logic/bp_btb.sv ====
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////
// Branch target buffer
// Direct mapped, valid/tag/target per entry,
// combinational read, clocked write
//////////////////////////////

module bp_btb import bp_pkg::*; #(
    parameter int unsigned INDEX_WIDTH = 6
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [INDEX_WIDTH-1:0]        rd_index_i,   // Fetch side index
    input  logic [INDEX_WIDTH-1:0]        wr_index_i,   // Commit side index
    input  logic                          wren_i,
    input  logic [XLEN-INDEX_WIDTH-3:0]   wr_tag_i,
    input  logic [XLEN-1:0]               wr_target_i,
    output logic                          valid_o,
    output logic [XLEN-INDEX_WIDTH-3:0]   rd_tag_o,
    output logic [XLEN-1:0]               rd_target_o
);

    localparam int unsigned TAG_WIDTH = XLEN - INDEX_WIDTH - 2;
    localparam int unsigned ENTRIES   = 2 ** INDEX_WIDTH;

    logic [ENTRIES-1:0]   valid_q;                      // One valid bit per entry
    logic [TAG_WIDTH-1:0] tag_q    [ENTRIES];
    logic [XLEN-1:0]      target_q [ENTRIES];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;                              // All entries empty
        end else if (wren_i) begin
            valid_q[wr_index_i] <= 1'b1;
        end
    end

    // Payload arrays
    always_ff @(posedge clk_i) begin
        if (wren_i) begin
            tag_q[wr_index_i]    <= wr_tag_i;
            target_q[wr_index_i] <= wr_target_i;
        end
    end

    assign valid_o     = valid_q[rd_index_i];           // Asynchronous read
    assign rd_tag_o    = tag_q[rd_index_i];
    assign rd_target_o = target_q[rd_index_i];

    // A write with an unknown index would corrupt an arbitrary entry
    a_wr_index_known: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        wren_i |-> !$isunknown(wr_index_i)
    );

endmodule

`default_nettype wire

// ==== logic/bp_pht.sv ====
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////
// Pattern history table
// Two-bit saturating counters,
// combinational read, clocked update
//////////////////////////////

module bp_pht import bp_pkg::*; #(
    parameter int unsigned INDEX_WIDTH = 8
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic [INDEX_WIDTH-1:0] rd_index_i,          // PC xor history at fetch
    input  logic                   update_en_i,
    input  logic [INDEX_WIDTH-1:0] update_index_i,      // PC xor history at commit
    input  logic                   br_taken_i,          // Resolved outcome
    output logic                   prediction_o
);

    localparam int unsigned ENTRIES = 2 ** INDEX_WIDTH;

    ctr_e pht_q [ENTRIES];
    ctr_e upd_ctr;                                      // Counter being trained
    ctr_e upd_next;
    ctr_e rd_ctr;

    assign upd_ctr = pht_q[update_index_i];

    // Saturating step toward the resolved outcome
    always_comb begin
        case (upd_ctr)
            STRONG_NT: upd_next = br_taken_i ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   upd_next = br_taken_i ? WEAK_T   : STRONG_NT;
            WEAK_T:    upd_next = br_taken_i ? STRONG_T : WEAK_NT;
            default:   upd_next = br_taken_i ? STRONG_T : WEAK_T;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht_q[i] <= WEAK_NT;                    // Weakly not taken
            end
        end else if (update_en_i) begin
            pht_q[update_index_i] <= upd_next;
        end
    end

    assign rd_ctr       = pht_q[rd_index_i];
    assign prediction_o = rd_ctr[1];                    // Upper bit is the direction

    // Training toward taken must always leave the entry out of strong not-taken
    a_taken_not_strong_nt: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (update_en_i && br_taken_i) |=> (pht_q[$past(update_index_i)] != STRONG_NT)
    );

endmodule

`default_nettype wire

// ==== logic/bp_ghr.sv ====
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////
// Global history register
// Speculative shift at fetch,
// restore on commit mispredict
//////////////////////////////

module bp_ghr #(
    parameter int unsigned HISTORY_WIDTH = 8
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     shift_en_i,        // Speculative update
    input  logic                     shift_bit_i,       // Predicted direction
    input  logic                     restore_en_i,      // Mispredict repair
    input  logic [HISTORY_WIDTH-1:0] restore_data_i,
    output logic [HISTORY_WIDTH-1:0] ghr_o
);

    logic [HISTORY_WIDTH-1:0] ghr_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr_q <= '0;
        end else if (restore_en_i) begin
            ghr_q <= restore_data_i;                    // Repair wins over shift
        end else if (shift_en_i) begin
            ghr_q <= {ghr_q[HISTORY_WIDTH-2:0], shift_bit_i};
        end
    end

    assign ghr_o = ghr_q;

    // The history feeds the PHT index, so an X here poisons every lookup
    a_ghr_known: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (restore_en_i || !shift_en_i) |=> !$isunknown(ghr_o)
    );

endmodule

`default_nettype wire

// ==== logic/gshare_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////
// Gshare branch predictor
// BTB hit, PHT direction, GHR repair,
// next-PC select and flush decision
//////////////////////////////

module gshare_predictor import bp_pkg::*; #(
    parameter int unsigned INDEX_WIDTH   = 6,
    parameter int unsigned HISTORY_WIDTH = 8
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic [XLEN-1:0]          fetch_pc_i,
    input  logic                     stall_i,
    input  logic                     commit_valid_i,     // Resolved branch present
    input  logic [XLEN-1:0]          commit_pc_i,
    input  logic [XLEN-1:0]          commit_target_i,
    input  logic                     commit_taken_i,     // Actual direction
    input  logic                     commit_pred_i,      // Direction predicted at fetch
    input  logic                     commit_btb_hit_i,   // Hit seen at fetch
    input  logic [HISTORY_WIDTH-1:0] commit_ghr_i,       // History seen at fetch
    output logic                     btb_hit_o,
    output logic                     prediction_o,
    output pc_sel_e                  pc_sel_o,
    output logic [XLEN-1:0]          btb_target_o,
    output logic                     flush_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o
);

    localparam int unsigned TAG_WIDTH = XLEN - INDEX_WIDTH - 2;

    logic [INDEX_WIDTH-1:0]   btb_rd_index;
    logic [INDEX_WIDTH-1:0]   btb_wr_index;
    logic [TAG_WIDTH-1:0]     fetch_tag;
    logic [TAG_WIDTH-1:0]     commit_tag;
    logic [TAG_WIDTH-1:0]     btb_rd_tag;
    logic                     btb_valid;
    logic                     btb_wren;
    logic [HISTORY_WIDTH-1:0] pht_rd_index;
    logic [HISTORY_WIDTH-1:0] pht_wr_index;
    logic                     pht_bit;
    logic                     mispredict;
    logic                     ghr_shift_en;

    // PC split, word offset bits dropped
    assign btb_rd_index = fetch_pc_i[INDEX_WIDTH+1:2];
    assign fetch_tag    = fetch_pc_i[XLEN-1:INDEX_WIDTH+2];
    assign btb_wr_index = commit_pc_i[INDEX_WIDTH+1:2];
    assign commit_tag   = commit_pc_i[XLEN-1:INDEX_WIDTH+2];

    assign pht_rd_index = fetch_pc_i[HISTORY_WIDTH+1:2] ^ ghr_o;          // Gshare hash
    assign pht_wr_index = commit_pc_i[HISTORY_WIDTH+1:2] ^ commit_ghr_i;  // Same hash at fetch time

    assign btb_hit_o    = btb_valid && (btb_rd_tag == fetch_tag);
    assign prediction_o = btb_hit_o & pht_bit;          // No target, no taken guess

    assign mispredict   = commit_valid_i && (commit_pred_i != commit_taken_i);
    assign btb_wren     = commit_valid_i && !commit_btb_hit_i && commit_taken_i;
    assign ghr_shift_en = btb_hit_o && !stall_i && !flush_o;

    bp_btb #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) btb_i (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rd_index_i  (btb_rd_index),
        .wr_index_i  (btb_wr_index),
        .wren_i      (btb_wren),
        .wr_tag_i    (commit_tag),
        .wr_target_i (commit_target_i),
        .valid_o     (btb_valid),
        .rd_tag_o    (btb_rd_tag),
        .rd_target_o (btb_target_o)
    );

    bp_pht #(
        .INDEX_WIDTH (HISTORY_WIDTH)
    ) pht_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .rd_index_i     (pht_rd_index),
        .update_en_i    (commit_valid_i),               // Every resolved branch trains
        .update_index_i (pht_wr_index),
        .br_taken_i     (commit_taken_i),
        .prediction_o   (pht_bit)
    );

    bp_ghr #(
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) ghr_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .shift_en_i     (ghr_shift_en),
        .shift_bit_i    (prediction_o),
        .restore_en_i   (mispredict),
        .restore_data_i ({commit_ghr_i[HISTORY_WIDTH-1:1], ~commit_ghr_i[0]}),  // Fix last guess
        .ghr_o          (ghr_o)
    );

    // Recovery first, then follow the prediction
    always_comb begin
        pc_sel_o = PC_SEQ;
        flush_o  = 1'b0;
        if (mispredict) begin
            flush_o  = 1'b1;                            // Squash wrong-path fetches
            pc_sel_o = commit_taken_i ? PC_RECOVER_TGT : PC_RECOVER_SEQ;
        end else if (prediction_o) begin
            pc_sel_o = PC_BTB;
        end
    end

    // A flush only ever comes from a resolved branch
    a_flush_from_commit: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        flush_o |-> commit_valid_i
    );

endmodule

`default_nettype wire

// ==== logic/bp_pc_gen.sv ====
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////
// Next-PC generator
// Four-way source mux into the fetch PC register
//////////////////////////////

module bp_pc_gen import bp_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h0000_1000
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            stall_i,                    // Fetch back-pressure
    input  logic            flush_i,                    // Redirect, beats stall
    input  pc_sel_e         pc_sel_i,
    input  logic [XLEN-1:0] btb_target_i,
    input  logic [XLEN-1:0] commit_pc_i,
    input  logic [XLEN-1:0] commit_target_i,
    output logic [XLEN-1:0] pc_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic            load_en;

    always_comb begin
        unique case (pc_sel_i)
            PC_SEQ:         pc_next = pc_q + XLEN'(4);
            PC_RECOVER_SEQ: pc_next = commit_pc_i + XLEN'(4);   // Fall through past branch
            PC_BTB:         pc_next = btb_target_i;
            PC_RECOVER_TGT: pc_next = commit_target_i;
        endcase
    end

    assign load_en = !stall_i || flush_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (load_en) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // Fetch addresses are whole instructions
    a_pc_aligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pc_o[1:0] == 2'b00
    );

endmodule

`default_nettype wire

// ==== logic/bp_fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////
// Fetch-side branch prediction top
// Gshare predictor plus fetch PC register
//////////////////////////////

module bp_fetch_unit import bp_pkg::*; #(
    parameter int unsigned     INDEX_WIDTH   = 6,
    parameter int unsigned     HISTORY_WIDTH = 8,
    parameter logic [XLEN-1:0] RESET_PC      = 32'h0000_1000
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     stall_i,
    input  logic                     commit_valid_i,
    input  logic [XLEN-1:0]          commit_pc_i,
    input  logic [XLEN-1:0]          commit_target_i,
    input  logic                     commit_taken_i,
    input  logic                     commit_pred_i,
    input  logic                     commit_btb_hit_i,
    input  logic [HISTORY_WIDTH-1:0] commit_ghr_i,
    output logic [XLEN-1:0]          fetch_pc_o,
    output logic                     pred_taken_o,
    output logic                     btb_hit_o,
    output logic [HISTORY_WIDTH-1:0] ghr_o,
    output logic                     flush_o
);

    pc_sel_e         pc_sel;                            // Predictor to PC mux
    logic [XLEN-1:0] btb_target;

    gshare_predictor #(
        .INDEX_WIDTH   (INDEX_WIDTH),
        .HISTORY_WIDTH (HISTORY_WIDTH)
    ) gshare_predictor_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .fetch_pc_i       (fetch_pc_o),
        .stall_i          (stall_i),
        .commit_valid_i   (commit_valid_i),
        .commit_pc_i      (commit_pc_i),
        .commit_target_i  (commit_target_i),
        .commit_taken_i   (commit_taken_i),
        .commit_pred_i    (commit_pred_i),
        .commit_btb_hit_i (commit_btb_hit_i),
        .commit_ghr_i     (commit_ghr_i),
        .btb_hit_o        (btb_hit_o),
        .prediction_o     (pred_taken_o),
        .pc_sel_o         (pc_sel),
        .btb_target_o     (btb_target),
        .flush_o          (flush_o),
        .ghr_o            (ghr_o)
    );

    bp_pc_gen #(
        .RESET_PC (RESET_PC)
    ) bp_pc_gen_i (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall_i),
        .flush_i         (flush_o),
        .pc_sel_i        (pc_sel),
        .btb_target_i    (btb_target),
        .commit_pc_i     (commit_pc_i),
        .commit_target_i (commit_target_i),
        .pc_o            (fetch_pc_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_bp_fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none
//////////////////////////////
// Fetch unit testbench
// Commit-stage stimulus, gshare reference
// model and per-cycle checks
//////////////////////////////

module tb_bp_fetch_unit import bp_pkg::*; ();

    localparam int unsigned     IDX_W      = 6;
    localparam int unsigned     HIST_W     = 8;
    localparam logic [XLEN-1:0] RST_PC     = 32'h0000_1000;
    localparam logic [XLEN-1:0] BR_BASE    = 32'h0000_2000;   // Branch pool for random commits
    localparam int unsigned     CLK_PERIOD = 8;
    localparam int unsigned     NUM_RAND   = 300;
    localparam int unsigned     NUM_CYCLES = NUM_RAND + 60;   // Directed part is about 30

    logic              clk_i;
    logic              arst_n_i;
    logic              stall_i;
    logic              commit_valid_i;
    logic [XLEN-1:0]   commit_pc_i;
    logic [XLEN-1:0]   commit_target_i;
    logic              commit_taken_i;
    logic              commit_pred_i;
    logic              commit_btb_hit_i;
    logic [HIST_W-1:0] commit_ghr_i;
    logic [XLEN-1:0]   fetch_pc_o;
    logic              pred_taken_o;
    logic              btb_hit_o;
    logic [HIST_W-1:0] ghr_o;
    logic              flush_o;

    // Reference tables
    logic                  m_valid [2**IDX_W];
    logic [XLEN-IDX_W-3:0] m_tag   [2**IDX_W];
    logic [XLEN-1:0]       m_tgt   [2**IDX_W];
    logic [1:0]            m_ctr   [2**HIST_W];
    logic [XLEN-1:0]       exp_pc;                        // Expected for the current cycle
    logic [XLEN-1:0]       nxt_pc;                        // Expected after the next edge
    logic [HIST_W-1:0]     exp_ghr;
    logic [HIST_W-1:0]     nxt_ghr;
    logic                  exp_hit;
    logic                  exp_pred;
    logic                  exp_flush;

    bp_fetch_unit #(
        .INDEX_WIDTH   (IDX_W),
        .HISTORY_WIDTH (HIST_W),
        .RESET_PC      (RST_PC)
    ) bp_fetch_unit_i (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .stall_i          (stall_i),
        .commit_valid_i   (commit_valid_i),
        .commit_pc_i      (commit_pc_i),
        .commit_target_i  (commit_target_i),
        .commit_taken_i   (commit_taken_i),
        .commit_pred_i    (commit_pred_i),
        .commit_btb_hit_i (commit_btb_hit_i),
        .commit_ghr_i     (commit_ghr_i),
        .fetch_pc_o       (fetch_pc_o),
        .pred_taken_o     (pred_taken_o),
        .btb_hit_o        (btb_hit_o),
        .ghr_o            (ghr_o),
        .flush_o          (flush_o)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] expv);
        $display("Fail %s got %h expected %h", name, got, expv);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Model runs at the falling edge, where DUT outputs and inputs are settled
    always @(negedge clk_i) begin : ref_model
        logic [IDX_W-1:0]  bi;
        logic [IDX_W-1:0]  wi;
        logic [HIST_W-1:0] ci;
        if (!arst_n_i) begin
            for (int i = 0; i < 2**IDX_W; i++) begin
                m_valid[i] = 1'b0;
            end
            for (int i = 0; i < 2**HIST_W; i++) begin
                m_ctr[i] = WEAK_NT;
            end
            nxt_pc    = RST_PC;
            nxt_ghr   = '0;
            exp_pc    = RST_PC;
            exp_ghr   = '0;
            exp_hit   = 1'b0;
            exp_pred  = 1'b0;
            exp_flush = 1'b0;
        end else begin
            exp_pc    = nxt_pc;
            exp_ghr   = nxt_ghr;
            bi        = exp_pc[IDX_W+1:2];
            exp_hit   = m_valid[bi] && (m_tag[bi] == exp_pc[XLEN-1:IDX_W+2]);
            exp_pred  = exp_hit && m_ctr[exp_pc[HIST_W+1:2] ^ ghr_o][1];
            exp_flush = commit_valid_i && (commit_pred_i != commit_taken_i);
            if (exp_flush) begin                          // Redirect wins over stall
                nxt_pc  = commit_taken_i ? commit_target_i : commit_pc_i + 32'd4;
                nxt_ghr = commit_ghr_i ^ HIST_W'(1);
            end else begin
                nxt_pc  = stall_i ? exp_pc : (exp_pred ? m_tgt[bi] : exp_pc + 32'd4);
                nxt_ghr = (exp_hit && !stall_i) ? {ghr_o[HIST_W-2:0], exp_pred} : ghr_o;
            end
            if (commit_valid_i) begin                     // Train after the lookup
                ci = commit_pc_i[HIST_W+1:2] ^ commit_ghr_i;
                wi = commit_pc_i[IDX_W+1:2];
                if (commit_taken_i && m_ctr[ci] != STRONG_T) begin
                    m_ctr[ci] = m_ctr[ci] + 2'd1;
                end else if (!commit_taken_i && m_ctr[ci] != STRONG_NT) begin
                    m_ctr[ci] = m_ctr[ci] - 2'd1;
                end
                if (commit_taken_i && !commit_btb_hit_i) begin
                    m_valid[wi] = 1'b1;
                    m_tag[wi]   = commit_pc_i[XLEN-1:IDX_W+2];
                    m_tgt[wi]   = commit_target_i;
                end
            end
        end
    end

    a_fetch_pc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fetch_pc_o === exp_pc)
        else report_mismatch("fetch_pc_o", $sampled(fetch_pc_o), $sampled(exp_pc));
    a_ghr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ghr_o === exp_ghr)
        else report_mismatch("ghr_o", $sampled(ghr_o), $sampled(exp_ghr));
    a_hit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        btb_hit_o === exp_hit)
        else report_mismatch("btb_hit_o", $sampled(btb_hit_o), $sampled(exp_hit));
    a_pred: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pred_taken_o === exp_pred)
        else report_mismatch("pred_taken_o", $sampled(pred_taken_o), $sampled(exp_pred));
    a_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        flush_o === exp_flush)
        else report_mismatch("flush_o", $sampled(flush_o), $sampled(exp_flush));

    task automatic step();
        @(posedge clk_i);
        #1;                                               // Drive just after the edge
    endtask

    task automatic run_cycles(input int n, input logic stall);
        repeat (n) begin
            step();
            stall_i        = stall;
            commit_valid_i = 1'b0;
        end
    endtask

    task automatic send_commit(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] tgt,
                               input logic taken, input logic pred, input logic hit,
                               input logic [HIST_W-1:0] ghr, input logic stall);
        step();
        stall_i          = stall;
        commit_valid_i   = 1'b1;
        commit_pc_i      = pc;
        commit_target_i  = tgt;
        commit_taken_i   = taken;
        commit_pred_i    = pred;
        commit_btb_hit_i = hit;
        commit_ghr_i     = ghr;
    endtask

    // Wrong taken guess at addr-4 steers fetch to addr with history hist
    task automatic redirect_to(input logic [XLEN-1:0] addr, input logic [HIST_W-1:0] hist);
        send_commit(addr - 32'd4, addr + 32'd64, 1'b0, 1'b1, 1'b1, hist ^ 8'h01, 1'b0);
    endtask

    initial begin : stimulus
        int unsigned       k;
        logic [HIST_W-1:0] g;
        void'($urandom(32'h532b3321));
        arst_n_i         = 1'b0;
        stall_i          = 1'b0;
        commit_valid_i   = 1'b0;
        commit_pc_i      = '0;
        commit_target_i  = '0;
        commit_taken_i   = 1'b0;
        commit_pred_i    = 1'b0;
        commit_btb_hit_i = 1'b0;
        commit_ghr_i     = '0;
        repeat (3) @(posedge clk_i);
        #1 arst_n_i = 1'b1;
        run_cycles(4, 1'b0);                              // Sequential fetch from reset
        send_commit(32'h1040, 32'h1200, 1'b1, 1'b0, 1'b1, 8'h5a, 1'b0);  // Missed taken
        run_cycles(2, 1'b0);
        send_commit(32'h1300, 32'h1400, 1'b0, 1'b1, 1'b1, 8'h33, 1'b0);  // Missed not taken
        run_cycles(2, 1'b0);
        redirect_to(BR_BASE, 8'h00);
        send_commit(BR_BASE, 32'h2400, 1'b1, 1'b0, 1'b0, 8'h00, 1'b0);  // Fill BTB entry
        run_cycles(1, 1'b0);
        redirect_to(BR_BASE, 8'h00);                      // Now hits and predicts taken
        run_cycles(3, 1'b0);
        run_cycles(3, 1'b1);                              // Stall holds PC and history
        send_commit(32'h1500, BR_BASE, 1'b1, 1'b0, 1'b1, ghr_o, 1'b1);  // Flush under stall
        run_cycles(2, 1'b1);
        run_cycles(1, 1'b0);
        for (int n = 0; n < NUM_RAND; n++) begin
            if ($urandom % 3 == 0) begin
                k = $urandom % 8;
                g = ($urandom % 2 == 0) ? ghr_o : HIST_W'($urandom);
                send_commit(BR_BASE + 4 * k, BR_BASE + 4 * ($urandom % 8),
                            ($urandom % 4) != 0, $urandom % 2, $urandom % 2, g,
                            ($urandom % 4) == 0);
            end else begin
                run_cycles(1, ($urandom % 4) == 0);
            end
        end
        run_cycles(3, 1'b0);
        $display("STATUS: PASS");
        $finish;
    end

    initial begin : watchdog
        #(NUM_CYCLES * CLK_PERIOD + 100);
        $display("Timeout: stimulus did not finish within %0d cycles", NUM_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/bp_pkg.sv
logic/bp_btb.sv
logic/bp_pht.sv
logic/bp_ghr.sv
logic/gshare_predictor.sv
logic/bp_pc_gen.sv
logic/bp_fetch_unit.sv
tb/tb_bp_fetch_unit.sv
